//--- rtl/rvc_isa_pkg.sv
`default_nettype none

package rvc_isa_pkg;

  //////////////////////////////
  // instruction widths
  //////////////////////////////

  // full RV32 instruction word
  localparam int unsigned XLEN_INSTR = 32;

  // one compressed parcel
  localparam int unsigned PARCEL_W = 16;

  //////////////////////////////
  // RV32I major opcodes
  //////////////////////////////

  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;

  //////////////////////////////
  // register numbers
  //////////////////////////////

  // link register for c.jal and c.jalr
  localparam logic [4:0] REG_RA = 5'd1;

  // stack pointer, implicit base of the sp-relative forms
  localparam logic [4:0] REG_SP = 5'd2;

  // rd', rs1' and rs2' cover x8..x15
  localparam logic [1:0] RVC_REG_PREFIX = 2'b01;

  // ebreak, produced by c.ebreak
  localparam logic [XLEN_INSTR-1:0] EBREAK_INSTR = 32'h0010_0073;

  //////////////////////////////
  // quadrant field, bits [1:0]
  //////////////////////////////

  // Q_FULL is not a quadrant, it marks a 32-bit instruction
  typedef enum logic [1:0] {
    Q0     = 2'b00,
    Q1     = 2'b01,
    Q2     = 2'b10,
    Q_FULL = 2'b11
  } quadrant_e;

endpackage

`default_nettype wire

//--- rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

  // slots per fetch bundle
  localparam int unsigned NUM_LANES = 2;

  // lane index width, at least one bit
  localparam int unsigned LANE_IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  //////////////////////////////
  // stage to stage payloads
  //////////////////////////////

  // one raw fetch slot after capture
  typedef struct packed {
    logic                                valid;
    logic [rvc_isa_pkg::XLEN_INSTR-1:0] instr;
  } lane_item_t;

  // one slot after expansion
  // instr is the RV32I form, zero when illegal is set
  typedef struct packed {
    logic                                valid;
    logic [rvc_isa_pkg::XLEN_INSTR-1:0] instr;
    logic                                compressed;
    logic                                illegal;
  } lane_result_t;

  // one slot as seen by issue
  typedef struct packed {
    logic                                valid;
    logic [rvc_isa_pkg::XLEN_INSTR-1:0] instr;
    logic                                compressed;
  } issue_slot_t;

endpackage

`default_nettype wire

//--- rtl/bundle_capture.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_capture (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic [decode_pkg::NUM_LANES-1:0]              fetch_valid_i,
  input  logic [decode_pkg::NUM_LANES-1:0][31:0]        fetch_instr_i,
  output decode_pkg::lane_item_t [decode_pkg::NUM_LANES-1:0] lane_o
);

  import decode_pkg::*;

  logic [NUM_LANES-1:0]       valid_q;
  logic [NUM_LANES-1:0][31:0] instr_q;

  // slot valid bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= fetch_valid_i;
    end
  end

  // words only load when their slot is present
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (fetch_valid_i[k]) begin
        instr_q[k] <= fetch_instr_i[k];
      end
    end
  end

  // split into per-lane items
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_o[k].valid = valid_q[k];
      lane_o[k].instr = instr_q[k];
    end
  end

endmodule

`default_nettype wire

//--- rtl/rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
  input  decode_pkg::lane_item_t   item_i,
  output decode_pkg::lane_result_t result_o
);

  import rvc_isa_pkg::*;
  import decode_pkg::*;

  logic [PARCEL_W-1:0]   c;
  quadrant_e             quad;
  logic [4:0]            rd_rs1;
  logic [4:0]            rs2;
  logic [4:0]            rd_p;
  logic [4:0]            rs2_p;
  logic [XLEN_INSTR-1:0] exp_instr;
  logic                  illegal;

  assign c    = item_i.instr[PARCEL_W-1:0];
  assign quad = quadrant_e'(item_i.instr[1:0]);

  // full register fields and the x8..x15 short forms
  assign rd_rs1 = c[11:7];
  assign rs2    = c[6:2];
  assign rd_p   = {RVC_REG_PREFIX, c[9:7]};
  assign rs2_p  = {RVC_REG_PREFIX, c[4:2]};

  always_comb begin
    exp_instr = '0;
    illegal   = 1'b0;

    unique case (quad)
      //////////////////////////////
      // quadrant 0
      //////////////////////////////
      Q0: begin
        case (c[15:13])
          3'b000: begin
            // c.addi4spn -> addi rd', sp, nzuimm
            exp_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, REG_SP, 3'b000,
                         rs2_p, OPCODE_OPIMM};
            illegal   = (c[12:5] == 8'b0);
          end
          3'b010: begin
            // c.lw -> lw rd', uimm(rs1')
            exp_instr = {5'b0, c[5], c[12:10], c[6], 2'b00, rd_p, 3'b010, rs2_p, OPCODE_LOAD};
          end
          3'b110: begin
            // c.sw -> sw rs2', uimm(rs1')
            exp_instr = {5'b0, c[5], c[12], rs2_p, rd_p, 3'b010, c[11:10], c[6], 2'b00,
                         OPCODE_STORE};
          end
          default: begin
            // float, Zc and reserved space
            illegal = 1'b1;
          end
        endcase
      end

      //////////////////////////////
      // quadrant 1
      //////////////////////////////
      Q1: begin
        case (c[15:13])
          3'b000: begin
            // c.addi, c.nop and the addi hints
            exp_instr = {{6{c[12]}}, c[12], c[6:2], rd_rs1, 3'b000, rd_rs1, OPCODE_OPIMM};
          end
          3'b001, 3'b101: begin
            // c.jal links through ra, c.j discards the link
            exp_instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}},
                         (c[15] ? 5'd0 : REG_RA), OPCODE_JAL};
          end
          3'b010: begin
            // c.li -> addi rd, x0, imm, rd zero is a hint
            exp_instr = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, rd_rs1, OPCODE_OPIMM};
          end
          3'b011: begin
            if ({c[12], c[6:2]} == 6'b0) begin
              // zero immediate is reserved for both forms
              illegal = 1'b1;
            end else if (rd_rs1 == REG_SP) begin
              // c.addi16sp -> addi sp, sp, nzimm
              exp_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, REG_SP, 3'b000,
                           REG_SP, OPCODE_OPIMM};
            end else begin
              // c.lui, rd zero is a hint
              exp_instr = {{15{c[12]}}, c[6:2], rd_rs1, OPCODE_LUI};
            end
          end
          3'b100: begin
            case (c[11:10])
              2'b00, 2'b01: begin
                // c.srli / c.srai, bit 12 would mean shamt above 31
                if (c[12]) begin
                  illegal = 1'b1;
                end else begin
                  exp_instr = {1'b0, c[10], 5'b0, c[6:2], rd_p, 3'b101, rd_p, OPCODE_OPIMM};
                end
              end
              2'b10: begin
                // c.andi
                exp_instr = {{6{c[12]}}, c[12], c[6:2], rd_p, 3'b111, rd_p, OPCODE_OPIMM};
              end
              default: begin
                case ({c[12], c[6:5]})
                  3'b000: exp_instr = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p, OPCODE_OP};
                  3'b001: exp_instr = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p, OPCODE_OP};
                  3'b010: exp_instr = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p, OPCODE_OP};
                  3'b011: exp_instr = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p, OPCODE_OP};
                  default: begin
                    // subw/addw, c.mul and the zext/sext/not group
                    illegal = 1'b1;
                  end
                endcase
              end
            endcase
          end
          default: begin
            // c.beqz / c.bnez, funct3 picked by bit 13
            exp_instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, rd_p, 2'b00, c[13], c[11:10], c[4:3],
                         c[12], OPCODE_BRANCH};
          end
        endcase
      end

      //////////////////////////////
      // quadrant 2
      //////////////////////////////
      Q2: begin
        case (c[15:13])
          3'b000: begin
            // c.slli, rd or shamt zero are hints
            if (c[12]) begin
              illegal = 1'b1;
            end else begin
              exp_instr = {7'b0, rs2, rd_rs1, 3'b001, rd_rs1, OPCODE_OPIMM};
            end
          end
          3'b010: begin
            // c.lwsp -> lw rd, uimm(sp)
            exp_instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00, REG_SP, 3'b010, rd_rs1,
                         OPCODE_LOAD};
            illegal   = (rd_rs1 == 5'd0);
          end
          3'b100: begin
            if (!c[12]) begin
              if (rs2 != 5'd0) begin
                // c.mv -> add rd, x0, rs2
                exp_instr = {7'b0, rs2, 5'd0, 3'b000, rd_rs1, OPCODE_OP};
              end else if (rd_rs1 != 5'd0) begin
                // c.jr -> jalr x0, 0(rs1)
                exp_instr = {12'b0, rd_rs1, 3'b000, 5'd0, OPCODE_JALR};
              end else begin
                illegal = 1'b1;
              end
            end else begin
              if (rs2 != 5'd0) begin
                // c.add -> add rd, rd, rs2
                exp_instr = {7'b0, rs2, rd_rs1, 3'b000, rd_rs1, OPCODE_OP};
              end else if (rd_rs1 != 5'd0) begin
                // c.jalr -> jalr ra, 0(rs1)
                exp_instr = {12'b0, rd_rs1, 3'b000, REG_RA, OPCODE_JALR};
              end else begin
                exp_instr = EBREAK_INSTR;
              end
            end
          end
          3'b110: begin
            // c.swsp -> sw rs2, uimm(sp)
            exp_instr = {4'b0, c[8:7], c[12], rs2, REG_SP, 3'b010, c[11:9], 2'b00,
                         OPCODE_STORE};
          end
          default: begin
            // cm.* loads, table jumps and float sp forms
            illegal = 1'b1;
          end
        endcase
      end

      Q_FULL: begin
        // 32-bit instruction goes through untouched
        exp_instr = item_i.instr;
      end
    endcase
  end

  assign result_o.valid      = item_i.valid;
  assign result_o.instr      = illegal ? '0 : exp_instr;
  assign result_o.compressed = (quad != Q_FULL);
  assign result_o.illegal    = illegal;

endmodule

`default_nettype wire

//--- rtl/issue_collect.sv
`timescale 1ns/1ps
`default_nettype none

module issue_collect (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  decode_pkg::lane_result_t [decode_pkg::NUM_LANES-1:0] result_i,
  output decode_pkg::issue_slot_t  [decode_pkg::NUM_LANES-1:0] issue_o,
  output logic                                                 exc_valid_o,
  output logic [decode_pkg::LANE_IDX_W-1:0]                    exc_lane_o
);

  import rvc_isa_pkg::*;
  import decode_pkg::*;

  logic [NUM_LANES-1:0]                 issue_ok;
  logic                                 stop;
  logic [LANE_IDX_W-1:0]                first_bad;
  logic [NUM_LANES-1:0]                 valid_q;
  logic [NUM_LANES-1:0][XLEN_INSTR-1:0] instr_q;
  logic [NUM_LANES-1:0]                 comp_q;
  logic                                 exc_valid_q;
  logic [LANE_IDX_W-1:0]                exc_lane_q;

  // walk up from lane 0, the first valid illegal lane blocks itself and all above
  always_comb begin
    stop      = 1'b0;
    first_bad = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      issue_ok[k] = result_i[k].valid && !result_i[k].illegal && !stop;
      if (result_i[k].valid && result_i[k].illegal && !stop) begin
        stop      = 1'b1;
        first_bad = LANE_IDX_W'(k);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q     <= '0;
      exc_valid_q <= 1'b0;
      exc_lane_q  <= '0;
    end else begin
      valid_q     <= issue_ok;
      exc_valid_q <= stop;
      exc_lane_q  <= first_bad;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      instr_q[k] <= result_i[k].instr;
      comp_q[k]  <= result_i[k].compressed;
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      issue_o[k].valid      = valid_q[k];
      issue_o[k].instr      = instr_q[k];
      issue_o[k].compressed = comp_q[k];
    end
  end

  assign exc_valid_o = exc_valid_q;
  assign exc_lane_o  = exc_lane_q;

endmodule

`default_nettype wire

//--- rtl/rvc_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_decode_stage (
  input  logic                                                         clk_i,
  input  logic                                                         rst_i,
  input  logic [decode_pkg::NUM_LANES-1:0]                             fetch_valid_i,
  input  logic [decode_pkg::NUM_LANES-1:0][rvc_isa_pkg::XLEN_INSTR-1:0] fetch_instr_i,
  output decode_pkg::issue_slot_t [decode_pkg::NUM_LANES-1:0]          issue_o,
  output logic                                                         exc_valid_o,
  output logic [decode_pkg::LANE_IDX_W-1:0]                            exc_lane_o
);

  import decode_pkg::*;

  lane_item_t   [NUM_LANES-1:0] lanes;
  lane_result_t [NUM_LANES-1:0] results;

  // first register stage
  bundle_capture u_capture (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .lane_o        (lanes)
  );

  // one expander per slot
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    rvc_expander u_expander (
      .item_i   (lanes[g]),
      .result_o (results[g])
    );
  end

  // second register stage with the issue stop
  issue_collect u_collect (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .result_i    (results),
    .issue_o     (issue_o),
    .exc_valid_o (exc_valid_o),
    .exc_lane_o  (exc_lane_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: name, stimulus word, expected RV32I word, compressed, illegal
// illegal rows carry a zero expansion since they are never issued

localparam int NAME_CHARS = 14;
localparam int NUM_VECS   = 34;

typedef struct packed {
  logic [8*NAME_CHARS-1:0] name;
  logic [31:0]             stim;
  logic [31:0]             instr;
  logic                    comp;
  logic                    ill;
} vector_t;

localparam vector_t VECTORS [NUM_VECS] = '{
  '{"c.addi4spn",    32'h0000_0040, 32'h0041_0413, 1'b1, 1'b0},
  '{"c.lw",          32'h0000_4144, 32'h0045_2483, 1'b1, 1'b0},
  '{"c.sw",          32'h0000_c504, 32'h0095_2423, 1'b1, 1'b0},
  '{"c.addi",        32'h0000_10fd, 32'hfff0_8093, 1'b1, 1'b0},
  '{"c.li.hint",     32'h0000_4015, 32'h0050_0013, 1'b1, 1'b0},
  '{"c.jal",         32'h0000_2011, 32'h0040_00ef, 1'b1, 1'b0},
  '{"c.j",           32'h0000_bffd, 32'hffff_f06f, 1'b1, 1'b0},
  '{"c.lui",         32'h0000_6285, 32'h0000_12b7, 1'b1, 1'b0},
  '{"c.addi16sp",    32'h0000_6141, 32'h0101_0113, 1'b1, 1'b0},
  '{"c.srli",        32'h0000_8005, 32'h0014_5413, 1'b1, 1'b0},
  '{"c.andi",        32'h0000_997d, 32'hfff5_7513, 1'b1, 1'b0},
  '{"c.sub",         32'h0000_8c05, 32'h4094_0433, 1'b1, 1'b0},
  '{"c.xor",         32'h0000_8c25, 32'h0094_4433, 1'b1, 1'b0},
  '{"c.beqz",        32'h0000_c401, 32'h0004_0463, 1'b1, 1'b0},
  '{"c.bnez",        32'h0000_fcf5, 32'hfe04_9ee3, 1'b1, 1'b0},
  '{"c.slli",        32'h0000_028e, 32'h0032_9293, 1'b1, 1'b0},
  '{"c.lwsp",        32'h0000_4092, 32'h0041_2083, 1'b1, 1'b0},
  '{"c.jr",          32'h0000_8082, 32'h0000_8067, 1'b1, 1'b0},
  '{"c.mv",          32'h0000_852e, 32'h00b0_0533, 1'b1, 1'b0},
  '{"c.ebreak",      32'h0000_9002, 32'h0010_0073, 1'b1, 1'b0},
  '{"c.jalr",        32'h0000_9282, 32'h0002_80e7, 1'b1, 1'b0},
  '{"c.add",         32'h0000_952e, 32'h00b5_0533, 1'b1, 1'b0},
  '{"c.swsp",        32'h0000_c406, 32'h0011_2423, 1'b1, 1'b0},
  '{"c.mv.hint",     32'h0000_8016, 32'h0050_0033, 1'b1, 1'b0},
  '{"full.addi",     32'h0010_0093, 32'h0010_0093, 1'b0, 1'b0},
  '{"ill.addi4spn",  32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.lui",       32'h0000_6281, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.addi16sp",  32'h0000_6101, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.srli",      32'h0000_9005, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.subw",      32'h0000_9c05, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.lwsp",      32'h0000_4002, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.jr",        32'h0000_8002, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.fld",       32'h0000_2000, 32'h0000_0000, 1'b1, 1'b1},
  '{"ill.lbu",       32'h0000_8000, 32'h0000_0000, 1'b1, 1'b1}
};

`endif

//--- testbench/tb_rvc_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvc_decode_stage;

  import decode_pkg::*;

  `include "tb_vectors.svh"

  localparam int RESET_CYCLES = 10;
  localparam int IN_ORDER     = NUM_VECS / NUM_LANES;
  localparam int NUM_BUNDLES  = IN_ORDER + 40;
  localparam int CYCLE_LIMIT  = 2 * NUM_BUNDLES + RESET_CYCLES + 20;

  // expected view of one bundle at the outputs, tag all ones marks reset
  typedef struct packed {
    logic [15:0]               tag;
    logic [NUM_LANES-1:0]      issue;
    logic [NUM_LANES-1:0][7:0] idx;
    logic                      exc;
    logic [LANE_IDX_W-1:0]     exc_lane;
  } expect_t;

  logic                       clk;
  logic                       rst;
  logic [NUM_LANES-1:0]       fetch_valid;
  logic [NUM_LANES-1:0][31:0] fetch_instr;
  issue_slot_t [NUM_LANES-1:0] issue;
  logic                       exc_valid;
  logic [LANE_IDX_W-1:0]      exc_lane;

  expect_t exp_q[$];
  int      seed     = 71677;
  int      cycles   = 0;
  int      n_tests  = 0;
  int      n_failed = 0;
  int      n_errors = 0;

  rvc_decode_stage u_dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .fetch_valid_i (fetch_valid),
    .fetch_instr_i (fetch_instr),
    .issue_o       (issue),
    .exc_valid_o   (exc_valid),
    .exc_lane_o    (exc_lane)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // table names are zero padded on the left
  function automatic string vec_name(input int i);
    string      s;
    int         b;
    logic [7:0] ch;
    s = "";
    for (b = NAME_CHARS - 1; b >= 0; b--) begin
      ch = VECTORS[i].name[b*8 +: 8];
      if (ch != 8'h00) begin
        s = $sformatf("%s%c", s, ch);
      end
    end
    return s;
  endfunction

  // issue stops at the lowest valid illegal lane
  function automatic expect_t predict_bundle(input logic [15:0] tag,
                                             input logic [NUM_LANES-1:0] vbits,
                                             input logic [NUM_LANES-1:0][7:0] idx);
    expect_t e;
    int      first;
    int      k;
    first = NUM_LANES;
    for (k = NUM_LANES - 1; k >= 0; k--) begin
      if (vbits[k] && VECTORS[idx[k]].ill) begin
        first = k;
      end
    end
    e.tag      = tag;
    e.idx      = idx;
    e.exc      = (first < NUM_LANES);
    e.exc_lane = e.exc ? LANE_IDX_W'(first) : '0;
    for (k = 0; k < NUM_LANES; k++) begin
      e.issue[k] = vbits[k] && !VECTORS[idx[k]].ill && (k < first);
    end
    return e;
  endfunction

  task automatic check_bundle(input expect_t e);
    string tname;
    string lname;
    int    k;
    int    errs_before;
    errs_before = n_errors;
    tname = (e.tag == '1) ? "reset" : $sformatf("bundle %0d", e.tag);
    for (k = 0; k < NUM_LANES; k++) begin
      lname = (e.tag == '1) ? "reset" : vec_name(e.idx[k]);
      assert (issue[k].valid === e.issue[k]) else begin
        $display("Error %s: lane %0d valid expected %b actual %b",
                 lname, k, e.issue[k], issue[k].valid);
        n_errors++;
      end
      if (e.issue[k]) begin
        assert (issue[k].instr === VECTORS[e.idx[k]].instr) else begin
          $display("Error %s: lane %0d instr expected %h actual %h",
                   lname, k, VECTORS[e.idx[k]].instr, issue[k].instr);
          n_errors++;
        end
        assert (issue[k].compressed === VECTORS[e.idx[k]].comp) else begin
          $display("Error %s: lane %0d compressed expected %b actual %b",
                   lname, k, VECTORS[e.idx[k]].comp, issue[k].compressed);
          n_errors++;
        end
      end
    end
    assert (exc_valid === e.exc) else begin
      $display("Error %s: exc_valid expected %b actual %b", tname, e.exc, exc_valid);
      n_errors++;
    end
    assert (exc_lane === e.exc_lane) else begin
      $display("Error %s: exc_lane expected %0d actual %0d", tname, e.exc_lane, exc_lane);
      n_errors++;
    end
    n_tests++;
    if (n_errors == errs_before) begin
      $display("%s: ok", tname);
    end else begin
      n_failed++;
      $display("%s: FAIL", tname);
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [NUM_LANES-1:0]      vbits;
    logic [NUM_LANES-1:0][7:0] idx;
    int                        r;
    int                        b;
    int                        k;
    rst         = 1'b1;
    fetch_valid = '0;
    fetch_instr = '0;
    // outputs lag the inputs by two cycles, the first two checks see reset state
    repeat (2) exp_q.push_back(predict_bundle('1, '0, '0));
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;

    // in order pairs first, then random pairs and valid bits, then idle flush
    for (b = 0; b < NUM_BUNDLES + 2; b++) begin
      @(posedge clk);
      #1;
      check_bundle(exp_q.pop_front());
      for (k = 0; k < NUM_LANES; k++) begin
        if (b < IN_ORDER) begin
          idx[k] = 8'(b * NUM_LANES + k);
        end else begin
          r      = $random(seed);
          idx[k] = 8'($unsigned(r) % NUM_VECS);
        end
        fetch_instr[k] = VECTORS[idx[k]].stim;
      end
      if (b < IN_ORDER) begin
        vbits = '1;
      end else if (b < NUM_BUNDLES) begin
        vbits = NUM_LANES'($random(seed));
      end else begin
        vbits = '0;
      end
      fetch_valid = vbits;
      exp_q.push_back(predict_bundle(16'(b), vbits, idx));
    end

    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
    if (n_failed == 0 && n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+testbench
rtl/rvc_isa_pkg.sv
rtl/decode_pkg.sv
rtl/bundle_capture.sv
rtl/rvc_expander.sv
rtl/issue_collect.sv
rtl/rvc_decode_stage.sv
testbench/tb_rvc_decode_stage.sv

//--- Bender.yml
package:
  name: rvc_decode_stage

sources:
  - rtl/rvc_isa_pkg.sv
  - rtl/decode_pkg.sv
  - rtl/bundle_capture.sv
  - rtl/rvc_expander.sv
  - rtl/issue_collect.sv
  - rtl/rvc_decode_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_rvc_decode_stage.sv
